//--- logic/frame_pkg.sv
// Frame classifier shared definitions
// Stream beat, header layout, key table and result types
package frame_pkg;

   // --------------------------------------------------
   // Widths and sizes
   // --------------------------------------------------
   localparam int byte_w          = 8;
   localparam int max_field_bytes = 16;
   localparam int field_w         = max_field_bytes * byte_w;

   localparam int hdr_bytes       = 4;
   localparam int key_bytes       = 16;
   localparam int key_w           = key_bytes * byte_w;

   // Header contents
   localparam logic [byte_w-1:0] hdr_magic = 8'hA5;
   localparam int flag_key_bit    = 0;

   // Key table
   localparam int table_entries   = 4;
   localparam int table_idx_w     = $clog2(table_entries);

   // --------------------------------------------------
   // Types
   // --------------------------------------------------
   // One byte on a stream
   typedef struct packed {
      logic [byte_w-1:0] data;
      logic              last;
   } axis_beat_t;

   // First received byte sits in the top byte
   typedef logic [field_w-1:0] field_t;

   // Header as it arrives, magic byte first
   typedef struct packed {
      logic [byte_w-1:0] magic;
      logic [byte_w-1:0] frame_type;
      logic [byte_w-1:0] flags;
      logic [byte_w-1:0] seq;
   } hdr_t;

   // Table write
   typedef struct packed {
      logic                   we;
      logic [table_idx_w-1:0] index;
      logic [key_w-1:0]       key;
      logic                   entry_valid;
   } cfg_t;

   // Per frame classification
   typedef struct packed {
      hdr_t                   hdr;
      logic                   hdr_ok;
      logic                   key_checked;
      logic                   key_hit;
      logic [table_idx_w-1:0] hit_index;
   } result_t;

endpackage

//--- logic/stream_field_extract.sv
// Stream field extractor
// Captures the leading bytes of each frame into a left-justified field
// and passes the rest of the frame on with back-pressure
`timescale 1ns/1ps

module stream_field_extract #(
   parameter int field_bytes = 4
) (
   input  logic                  aclk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  frame_pkg::axis_beat_t s_beat,
   input  logic                  s_valid,
   output logic                  s_ready,
   output frame_pkg::axis_beat_t m_beat,
   output logic                  m_valid,
   input  logic                  m_ready,
   output frame_pkg::field_t     value,
   output logic                  out_valid
);

   localparam int cnt_w    = $clog2(frame_pkg::max_field_bytes + 1);
   localparam int pad_w    = (frame_pkg::max_field_bytes - field_bytes) * frame_pkg::byte_w;
   localparam int shift_lo = frame_pkg::field_w - frame_pkg::byte_w;
   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(field_bytes - 1);

   typedef enum logic [1:0] {
      ph_idle,
      ph_capture,
      ph_forward,
      ph_bypass
   } phase_t;

   phase_t            phase;
   logic [cnt_w-1:0]  cnt;
   logic              en_seen;
   frame_pkg::field_t shift_q;
   logic              en_now;
   logic              take;
   logic              xfer;
   logic              field_done;

   // --------------------------------------------------
   // Byte steering
   // --------------------------------------------------
   // Enable may pulse before the first byte shows up, so hold it
   assign en_now = enable | en_seen;

   // Byte belongs to the field
   assign take = (phase == ph_capture) || ((phase == ph_idle) && en_now);

   // Field bytes are always taken, everything else follows downstream
   assign s_ready = take | m_ready;
   assign m_valid = s_valid & ~take;
   assign m_beat  = s_beat;

   assign xfer       = s_valid & s_ready;
   assign field_done = take & xfer & (cnt == last_cnt);

   // --------------------------------------------------
   // Field register
   // --------------------------------------------------
   // Older bytes fall off the top once the field is left-justified
   always_ff @(posedge aclk) begin
      if (take && xfer) begin
         shift_q <= {shift_q[shift_lo-1:0], s_beat.data};
      end
   end

   // Low pad bytes come out as zero
   assign value = shift_q << pad_w;

   // --------------------------------------------------
   // Phase and byte counter
   // --------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         phase     <= ph_idle;
         cnt       <= '0;
         en_seen   <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= field_done;

         // Enable is consumed by the first byte of the frame
         if (phase == ph_idle) begin
            if (s_valid) begin
               en_seen <= 1'b0;
            end else if (enable) begin
               en_seen <= 1'b1;
            end
         end

         if (take) begin
            if (xfer) begin
               if (s_beat.last) begin
                  // Frame over, short or exact
                  phase <= ph_idle;
                  cnt   <= '0;
               end else if (cnt == last_cnt) begin
                  phase <= ph_forward;
                  cnt   <= '0;
               end else begin
                  phase <= ph_capture;
                  cnt   <= cnt + 1'b1;
               end
            end
         end else if (s_valid) begin
            // Pass through until the last beat leaves
            if (xfer && s_beat.last) begin
               phase <= ph_idle;
            end else if (phase == ph_idle) begin
               phase <= ph_bypass;
            end
         end
      end
   end

endmodule

//--- logic/frame_header_decode.sv
// Frame header decoder
// Splits the captured header into fields and decides whether a key follows
`timescale 1ns/1ps

module frame_header_decode (
   input  frame_pkg::field_t value,
   input  logic              valid,
   output frame_pkg::hdr_t   hdr,
   output logic              hdr_ok,
   output logic              key_en
);

   localparam int hdr_w = frame_pkg::hdr_bytes * frame_pkg::byte_w;

   // --------------------------------------------------
   // Field split
   // --------------------------------------------------
   // Header occupies the top bytes of the left-justified field
   assign hdr = frame_pkg::hdr_t'(value[frame_pkg::field_w-1 -: hdr_w]);

   // Only the magic byte is checked
   assign hdr_ok = (hdr.magic == frame_pkg::hdr_magic);

   // --------------------------------------------------
   // Key stage control
   // --------------------------------------------------
   // High only in the cycle the header completes
   assign key_en = valid & hdr_ok & hdr.flags[frame_pkg::flag_key_bit];

endmodule

//--- logic/key_lookup.sv
// Key lookup table
// Matches the captured key against programmable entries and issues
// one result strobe per frame
`timescale 1ns/1ps

module key_lookup (
   input  logic               aclk,
   input  logic               rst_n,
   input  frame_pkg::cfg_t    cfg,
   input  frame_pkg::hdr_t    hdr,
   input  logic               hdr_ok,
   input  logic               key_en,
   input  logic               hdr_valid,
   input  frame_pkg::field_t  key,
   input  logic               key_valid,
   output frame_pkg::result_t result,
   output logic               result_valid
);

   localparam int entries = frame_pkg::table_entries;
   localparam int idx_w   = frame_pkg::table_idx_w;
   localparam int key_w   = frame_pkg::key_w;

   logic [key_w-1:0]   tbl_key [entries];
   logic [entries-1:0] tbl_vld;
   frame_pkg::hdr_t    hdr_q;
   logic               key_pending;
   logic [key_w-1:0]   key_in;
   logic               key_hit;
   logic [idx_w-1:0]   hit_index;
   logic               key_done;

   // --------------------------------------------------
   // Key table
   // --------------------------------------------------
   always_ff @(posedge aclk) begin
      if (cfg.we) begin
         tbl_key[cfg.index] <= cfg.key;
      end
   end

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         tbl_vld <= '0;
      end else if (cfg.we) begin
         tbl_vld[cfg.index] <= cfg.entry_valid;
      end
   end

   // --------------------------------------------------
   // Parallel compare
   // --------------------------------------------------
   assign key_in = key[frame_pkg::field_w-1 -: key_w];

   // Scan downwards so the lowest matching entry wins
   always_comb begin
      key_hit   = 1'b0;
      hit_index = '0;
      for (int i = entries - 1; i >= 0; i--) begin
         if (tbl_vld[i] && (tbl_key[i] == key_in)) begin
            key_hit   = 1'b1;
            hit_index = idx_w'(i);
         end
      end
   end

   assign key_done = key_valid & key_pending;

   // --------------------------------------------------
   // Result sequencing
   // --------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         key_pending  <= 1'b0;
         result_valid <= 1'b0;
      end else begin
         result_valid <= 1'b0;
         if (hdr_valid) begin
            // No key expected, report straight away
            key_pending  <= key_en;
            result_valid <= ~key_en;
         end else if (key_done) begin
            key_pending  <= 1'b0;
            result_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (hdr_valid) begin
         hdr_q <= hdr;
      end

      if (hdr_valid && !key_en) begin
         result.hdr         <= hdr;
         result.hdr_ok      <= hdr_ok;
         result.key_checked <= 1'b0;
         result.key_hit     <= 1'b0;
         result.hit_index   <= '0;
      end else if (!hdr_valid && key_done) begin
         // Key stage only runs behind a good header
         result.hdr         <= hdr_q;
         result.hdr_ok      <= 1'b1;
         result.key_checked <= 1'b1;
         result.key_hit     <= key_hit;
         result.hit_index   <= hit_index;
      end
   end

endmodule

//--- logic/frame_classifier_top.sv
// Frame classifier top level
// Strips header and key from each frame, classifies it and forwards the payload
`timescale 1ns/1ps

module frame_classifier_top (
   input  logic                  aclk,
   input  logic                  rst_n,
   input  frame_pkg::axis_beat_t s_beat,
   input  logic                  s_valid,
   output logic                  s_ready,
   output frame_pkg::axis_beat_t m_beat,
   output logic                  m_valid,
   input  logic                  m_ready,
   input  frame_pkg::cfg_t       cfg,
   output frame_pkg::result_t    result,
   output logic                  result_valid
);

   // Stream between header and key stages
   frame_pkg::axis_beat_t mid_beat;
   logic                  mid_valid;
   logic                  mid_ready;

   frame_pkg::field_t     hdr_value;
   logic                  hdr_valid;
   frame_pkg::hdr_t       hdr;
   logic                  hdr_ok;
   logic                  key_en;
   frame_pkg::field_t     key_value;
   logic                  key_valid;

   // --------------------------------------------------
   // Header stage, always active
   // --------------------------------------------------
   stream_field_extract #(
      .field_bytes (frame_pkg::hdr_bytes)
   ) u_hdr_extract (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .enable    (1'b1),
      .s_beat    (s_beat),
      .s_valid   (s_valid),
      .s_ready   (s_ready),
      .m_beat    (mid_beat),
      .m_valid   (mid_valid),
      .m_ready   (mid_ready),
      .value     (hdr_value),
      .out_valid (hdr_valid)
   );

   frame_header_decode u_hdr_decode (
      .value  (hdr_value),
      .valid  (hdr_valid),
      .hdr    (hdr),
      .hdr_ok (hdr_ok),
      .key_en (key_en)
   );

   // --------------------------------------------------
   // Key stage, only for frames that carry a key
   // --------------------------------------------------
   stream_field_extract #(
      .field_bytes (frame_pkg::key_bytes)
   ) u_key_extract (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .enable    (key_en),
      .s_beat    (mid_beat),
      .s_valid   (mid_valid),
      .s_ready   (mid_ready),
      .m_beat    (m_beat),
      .m_valid   (m_valid),
      .m_ready   (m_ready),
      .value     (key_value),
      .out_valid (key_valid)
   );

   key_lookup u_key_lookup (
      .aclk         (aclk),
      .rst_n        (rst_n),
      .cfg          (cfg),
      .hdr          (hdr),
      .hdr_ok       (hdr_ok),
      .key_en       (key_en),
      .hdr_valid    (hdr_valid),
      .key          (key_value),
      .key_valid    (key_valid),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

//--- test/frame_classifier_sva.sv
// Protocol checks for the frame classifier
// Reset values, stream hold rules and single-cycle result strobes
`timescale 1ns/1ps

module frame_classifier_sva (
   input logic                  aclk,
   input logic                  rst_n,
   input frame_pkg::axis_beat_t s_beat,
   input logic                  s_valid,
   input logic                  s_ready,
   input frame_pkg::axis_beat_t mid_beat,
   input logic                  mid_valid,
   input logic                  mid_ready,
   input frame_pkg::axis_beat_t m_beat,
   input logic                  m_valid,
   input logic                  m_ready,
   input logic                  hdr_valid,
   input logic                  key_valid,
   input logic                  result_valid
);

   int fail_count = 0;

   // Idle outputs while reset is applied
   a_reset: assert property (@(posedge aclk)
      !rst_n |-> !result_valid && !m_valid && s_ready && !hdr_valid && !key_valid)
      else begin
         $error("outputs not at reset values during reset");
         fail_count++;
      end

   // --------------------------------------------------
   // Valid held with a stable beat until transfer
   // --------------------------------------------------
   a_s_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      s_valid && !s_ready |=> s_valid && $stable(s_beat))
      else begin
         $error("input stream beat dropped or changed before transfer");
         fail_count++;
      end

   a_mid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      mid_valid && !mid_ready |=> mid_valid && $stable(mid_beat))
      else begin
         $error("internal stream beat dropped or changed before transfer");
         fail_count++;
      end

   a_m_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      m_valid && !m_ready |=> m_valid && $stable(m_beat))
      else begin
         $error("output stream beat dropped or changed before transfer");
         fail_count++;
      end

   // One result strobe per frame, never two cycles long
   a_result_pulse: assert property (@(posedge aclk) disable iff (!rst_n)
      result_valid |=> !result_valid)
      else begin
         $error("result_valid high on two cycles in a row");
         fail_count++;
      end

endmodule

bind frame_classifier_top frame_classifier_sva u_sva (.*);

//--- test/tb_frame_classifier.sv
// Testbench for the frame classifier
// Sends framed byte streams, models header decode and key lookup,
// and checks results and payload under random back-pressure
`timescale 1ns/1ps

module tb_frame_classifier;

   localparam logic [31:0] seed_init = 32'h1a693df7;

   logic                    aclk;
   logic                    rst_n;
   frame_pkg::axis_beat_t   s_beat;
   logic                    s_valid;
   logic                    s_ready;
   frame_pkg::axis_beat_t   m_beat;
   logic                    m_valid;
   logic                    m_ready;
   frame_pkg::cfg_t         cfg;
   frame_pkg::result_t      result;
   logic                    result_valid;

   // Reference model of the key table and the expected outputs
   logic [frame_pkg::key_w-1:0]         model_key [frame_pkg::table_entries];
   logic [frame_pkg::table_entries-1:0] model_vld;
   logic [frame_pkg::key_w-1:0]         keys [4];
   frame_pkg::result_t                  exp_res [$];
   frame_pkg::axis_beat_t               exp_pay [$];
   frame_pkg::result_t                  res_want;
   frame_pkg::axis_beat_t               pay_want;

   integer      ready_seed;
   integer      frame_seed;
   logic [31:0] ready_rnd;
   logic [31:0] rnd;
   int          frame_no = 0;
   int          stim_bytes = 0;
   int          cycles = 0;
   int          res_errors = 0;
   int          pay_errors = 0;
   int          proto_errors = 0;

   frame_classifier_top i_frame_classifier_top (
      .aclk         (aclk),
      .rst_n        (rst_n),
      .s_beat       (s_beat),
      .s_valid      (s_valid),
      .s_ready      (s_ready),
      .m_beat       (m_beat),
      .m_valid      (m_valid),
      .m_ready      (m_ready),
      .cfg          (cfg),
      .result       (result),
      .result_valid (result_valid)
   );

   always #50 aclk = ~aclk;

   // Downstream back-pressure
   always @(negedge aclk) begin
      if (rst_n) begin
         ready_rnd = $random(ready_seed);
         m_ready <= (ready_rnd[1:0] != 2'b00);
      end
   end

   // --------------------------------------------------
   // Stimulus tasks
   // --------------------------------------------------
   task automatic write_entry(input logic [frame_pkg::table_idx_w-1:0] idx,
                              input logic [frame_pkg::key_w-1:0] k, input logic v);
      @(negedge aclk);
      cfg.we          <= 1'b1;
      cfg.index       <= idx;
      cfg.key         <= k;
      cfg.entry_valid <= v;
      model_key[idx] = k;
      model_vld[idx] = v;
      @(negedge aclk);
      cfg.we <= 1'b0;
   endtask

   // Header, 16 key bytes, then payload; expected outputs queued first
   task automatic send_frame(input logic [7:0] magic, input logic [7:0] flags,
                             input logic [frame_pkg::key_w-1:0] key, input int pay_len);
      logic [7:0]            bytes [$];
      logic [31:0]           r;
      frame_pkg::result_t    er;
      frame_pkg::axis_beat_t b;
      int                    n;
      int                    first;
      bytes.push_back(magic);
      bytes.push_back(8'h3c ^ frame_no[7:0]);
      bytes.push_back(flags);
      bytes.push_back(frame_no[7:0]);
      for (int i = 0; i < frame_pkg::key_bytes; i++) begin
         bytes.push_back(key[frame_pkg::key_w - 1 - 8 * i -: 8]);
      end
      for (int i = 0; i < pay_len; i++) begin
         r = $random(frame_seed);
         bytes.push_back(r[7:0]);
      end
      n  = bytes.size();
      er = '0;
      er.hdr         = {bytes[0], bytes[1], bytes[2], bytes[3]};
      er.hdr_ok      = (magic == frame_pkg::hdr_magic);
      er.key_checked = er.hdr_ok && flags[0];
      // Lowest valid matching entry wins
      for (int e = 0; e < frame_pkg::table_entries; e++) begin
         if (er.key_checked && !er.key_hit && model_vld[e] && model_key[e] == key) begin
            er.key_hit   = 1'b1;
            er.hit_index = frame_pkg::table_idx_w'(e);
         end
      end
      exp_res.push_back(er);
      first = er.key_checked ? frame_pkg::hdr_bytes + frame_pkg::key_bytes : frame_pkg::hdr_bytes;
      for (int i = first; i < n; i++) begin
         b.data = bytes[i];
         b.last = (i == n - 1);
         exp_pay.push_back(b);
      end
      stim_bytes += n;
      for (int i = 0; i < n; i++) begin
         @(negedge aclk);
         s_beat.data <= bytes[i];
         s_beat.last <= (i == n - 1);
         s_valid     <= 1'b1;
         @(posedge aclk);
         while (!s_ready) @(posedge aclk);
      end
      @(negedge aclk);
      s_valid <= 1'b0;
      frame_no++;
   endtask

   task automatic wait_drained();
      while (exp_res.size() != 0 || exp_pay.size() != 0) @(posedge aclk);
      @(negedge aclk);
   endtask

   // --------------------------------------------------
   // Output checks
   // --------------------------------------------------
   always @(posedge aclk) begin
      if (rst_n && result_valid) begin
         assert (exp_res.size() != 0) else begin
            $display("[ERROR] %0t result %h with no frame pending", $time, result);
            res_errors++;
         end
         if (exp_res.size() != 0) begin
            res_want = exp_res.pop_front();
            assert (result.hdr == res_want.hdr && result.hdr_ok == res_want.hdr_ok
                    && result.key_checked == res_want.key_checked
                    && result.key_hit == res_want.key_hit
                    && (!res_want.key_hit || result.hit_index == res_want.hit_index)) else begin
               $display("[ERROR] %0t result %h, expected %h", $time, result, res_want);
               res_errors++;
            end
         end
      end
      if (rst_n && m_valid && m_ready) begin
         assert (exp_pay.size() != 0) else begin
            $display("[ERROR] %0t payload byte %h with none expected", $time, m_beat.data);
            pay_errors++;
         end
         if (exp_pay.size() != 0) begin
            pay_want = exp_pay.pop_front();
            assert (m_beat == pay_want) else begin
               $display("[ERROR] %0t payload %h last %b, expected %h last %b", $time,
                        m_beat.data, m_beat.last, pay_want.data, pay_want.last);
               pay_errors++;
            end
         end
      end
   end

   always @(posedge aclk) begin
      cycles++;
      if (cycles > 2 * stim_bytes + 200) begin
         $display("Timeout after %0d cycles, %0d results and %0d payload bytes never arrived",
                  cycles, exp_res.size(), exp_pay.size());
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      ready_seed = seed_init;
      frame_seed = seed_init;
      aclk       = 1'b0;
      rst_n      = 1'b0;
      s_beat     = '0;
      s_valid    = 1'b0;
      m_ready    = 1'b0;
      cfg        = '0;
      model_vld  = '0;
      keys[0] = 128'h00112233_44556677_8899aabb_ccddeeff;
      keys[1] = 128'hdeadbeef_01020304_a5a5a5a5_0f1e2d3c;
      keys[2] = 128'h13579bdf_2468ace0_fedcba98_76543210;
      keys[3] = 128'h0badf00d_11111111_22222222_33333333;
      repeat (8) @(negedge aclk);
      rst_n <= 1'b1;
      @(posedge aclk);
      assert (!result_valid && !m_valid && s_ready) else begin
         $display("[ERROR] %0t outputs not idle after reset", $time);
         res_errors++;
      end

      // Duplicate key in entries 1 and 2
      write_entry(2'd0, keys[0], 1'b1);
      write_entry(2'd1, keys[1], 1'b1);
      write_entry(2'd2, keys[1], 1'b1);
      write_entry(2'd3, keys[2], 1'b1);
      send_frame(frame_pkg::hdr_magic, 8'h01, keys[0], 5);
      send_frame(frame_pkg::hdr_magic, 8'h01, keys[1], 3);
      send_frame(frame_pkg::hdr_magic, 8'h01, keys[2], 1);
      send_frame(8'h5a, 8'h01, keys[0], 4);
      send_frame(frame_pkg::hdr_magic, 8'h00, keys[0], 2);
      send_frame(frame_pkg::hdr_magic, 8'h01, keys[3], 3);
      wait_drained();

      // Invalidated entries stop matching
      write_entry(2'd3, keys[2], 1'b0);
      write_entry(2'd1, keys[1], 1'b0);
      send_frame(frame_pkg::hdr_magic, 8'h01, keys[2], 2);
      send_frame(frame_pkg::hdr_magic, 8'h03, keys[1], 2);
      wait_drained();

      for (int f = 0; f < 12; f++) begin
         rnd = $random(frame_seed);
         send_frame((rnd[1:0] == 2'b00) ? 8'h5a : frame_pkg::hdr_magic, rnd[23:16],
                    keys[rnd[6:5]], 1 + int'(rnd[10:8]));
      end
      wait_drained();
      repeat (4) @(posedge aclk);

      proto_errors = i_frame_classifier_top.u_sva.fail_count;
      $display("Error counts: result %0d, payload %0d, protocol %0d",
               res_errors, pay_errors, proto_errors);
      if (res_errors + pay_errors + proto_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
logic/frame_pkg.sv
logic/stream_field_extract.sv
logic/frame_header_decode.sv
logic/key_lookup.sv
logic/frame_classifier_top.sv
test/frame_classifier_sva.sv
test/tb_frame_classifier.sv

//--- Makefile
# Verilator flow for the frame classifier testbench
TOP := tb_frame_classifier
OBJ := obj_dir

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir $(OBJ) -o sim

run: build
	./$(OBJ)/sim | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all build run lint clean
